// File: hdl/cft_bus_pkg.sv
////////////////////////////////////////////////////////////
// Shared bus board definitions
// Microcode read and write address codes
// Address word views and the constant table
////////////////////////////////////////////////////////////

package cft_bus_pkg;

   ////////////////////////////////////////////////////////////
   // Microcode address codes
   ////////////////////////////////////////////////////////////

   localparam logic [4:0] WADDR_AR         = 5'h01;  // Load address register
   localparam logic [4:0] WADDR_MBN        = 5'h08;  // Load bank register MB[ir]
   localparam logic [4:0] RADDR_DB         = 5'h01;  // Data bus onto processor bus
   localparam logic [4:0] RADDR_MBN        = 5'h08;  // MB[ir] onto processor bus
   localparam logic [4:0] RADDR_CONST_BASE = 5'h10;  // First of 16 constant codes

   ////////////////////////////////////////////////////////////
   // Address word, memory and I/O views
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [7:0]  bank;    // Bank register byte
      logic [15:0] offset;  // AR value, page in top 3 bits
   } cft_mem_view_t;

   typedef struct packed {
      logic [13:0] unused;  // Zero in I/O cycles
      logic [1:0]  blk;     // I/O block 0xx-3xx
      logic [7:0]  port;    // Port within block
   } cft_io_view_t;

   typedef union packed {
      cft_mem_view_t mem;
      cft_io_view_t  io;
   } cft_addr_u;

   // Constant store contents, one word per index
   function automatic logic [15:0] const_value(input logic [3:0] idx);
      case (idx)
         4'h0:    return 16'h0000;
         4'h1:    return 16'h0001;
         4'h2:    return 16'h0002;
         4'h3:    return 16'h0003;
         4'h4:    return 16'h0004;
         4'h5:    return 16'h0005;
         4'h6:    return 16'h0006;
         4'h7:    return 16'h0007;
         4'h8:    return 16'h0008;    // Interrupt vector base
         4'h9:    return 16'h000c;
         4'ha:    return 16'h0010;
         4'hb:    return 16'h0020;
         4'hc:    return 16'h0040;
         4'hd:    return 16'h0080;
         4'he:    return 16'h00ff;    // Byte mask
         default: return 16'hffff;    // All ones
      endcase
   endfunction

endpackage

// File: hdl/reg_ar.sv
////////////////////////////////////////////////////////////
// Address register, first pipeline stage
// Loaded from the processor bus on the AR write code
////////////////////////////////////////////////////////////

module reg_ar (
   input  logic        clk,      // Board clock
   input  logic        reset,    // Sync, active high
   input  logic [4:0]  waddr,    // Microcode write address
   input  logic [15:0] ibus_in,  // Processor bus, input side
   output logic [15:0] ar        // Current memory/I/O address
);

   import cft_bus_pkg::*;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   logic ar_we;   // AR load strobe
   logic [15:0] ar_q;

   assign ar_we = (waddr == WADDR_AR);  // Single code loads AR

   ////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ar_q <= 16'h0000;               // Address zero out of reset
      end else if (ar_we) begin
         ar_q <= ibus_in;                // Whole word from the bus
      end
   end

   // Straight into the banking unit
   assign ar = ar_q;

endmodule

// File: hdl/mbu.sv
////////////////////////////////////////////////////////////
// Memory banking unit
// Eight bank registers, 16 to 24 bit address extension,
// bank register reads and front panel byte select
////////////////////////////////////////////////////////////

module mbu #(
   parameter logic [7:0] BOOT_BANK = 8'h00  // Bank register reset value
) (
   input  logic        clk,       // Board clock
   input  logic        reset,     // Sync, active high
   input  logic [4:0]  waddr,     // Microcode write address
   input  logic [4:0]  raddr,     // Microcode read address
   input  logic [2:0]  ir,        // IR[2:0] bank index
   input  logic [15:0] ibus_in,   // Processor bus, input side
   input  logic [15:0] ar,        // From address register
   input  logic        nio,       // I/O cycle, active low
   input  logic        nfparh,    // Front panel wants high byte
   output logic [23:0] ab,        // 24-bit address bus
   output logic [7:0]  mb_rdata,  // Bank register read data
   output logic        mb_rd,     // Bank register read select
   output logic [7:0]  fpd        // Front panel data
);

   import cft_bus_pkg::*;

   logic [7:0] mb [8];   // Bank registers MB0-MB7
   logic       mb_we;    // Bank register write strobe
   cft_addr_u  ab_next;  // Extended address, pre-register
   cft_addr_u  ab_q;     // Registered address bus

   ////////////////////////////////////////////////////////////
   // Bank registers
   ////////////////////////////////////////////////////////////

   assign mb_we = (waddr == WADDR_MBN);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            mb[i] <= BOOT_BANK;           // All banks point at boot bank
         end
      end else if (mb_we) begin
         mb[ir] <= ibus_in[7:0];          // Low byte only
      end
   end

   ////////////////////////////////////////////////////////////
   // Address extension
   ////////////////////////////////////////////////////////////

   always_comb begin
      ab_next.mem.offset = ar;            // Low 16 bits pass as is
      if (!nio) begin
         ab_next.mem.bank = 8'h00;        // I/O space has no bank
      end else begin
         // Page (top three AR bits) picks the bank register
         ab_next.mem.bank = mb[ab_next.mem.offset[15:13]];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ab_q <= '0;
      end else begin
         ab_q <= ab_next;                 // One cycle behind AR
      end
   end

   assign ab = ab_q;

   ////////////////////////////////////////////////////////////
   // Reads and front panel
   ////////////////////////////////////////////////////////////

   assign mb_rd    = (raddr == RADDR_MBN);  // Own read decode
   assign mb_rdata = mb[ir];                // Same index as writes

   // Low nfparh asks for the bank byte
   assign fpd = nfparh ? ab_q.mem.offset[7:0] : ab_q.mem.bank;

endmodule

// File: hdl/databus.sv
////////////////////////////////////////////////////////////
// Data bus driver
// I/O block decoder, write cycle FSM with wait states,
// data bus read path onto the processor bus
////////////////////////////////////////////////////////////

module databus (
   input  logic        clk,        // Board clock
   input  logic        reset,      // Sync, active high
   input  logic        nmem,       // Memory cycle, active low
   input  logic        nio,        // I/O cycle, active low
   input  logic        nr,         // Read strobe, active low
   input  logic        nwen,       // Write enable, active low
   input  logic        nws,        // Wait state, active low
   input  logic        nhalt,      // Halted, active low
   input  logic [4:0]  raddr,      // Microcode read address
   input  logic [23:0] ab,         // Address bus
   input  logic [15:0] ibus_in,    // Processor bus, input side
   input  logic [15:0] db_in,      // Data bus, input side
   output logic [15:0] db_out,     // Data bus, output side
   output logic        nw,         // Write strobe, active low
   output logic        nsysdev,    // I/O 000-0FF
   output logic        niodev1xx,  // I/O 100-1FF
   output logic        niodev2xx,  // I/O 200-2FF
   output logic        niodev3xx,  // I/O 300-3FF
   output logic [15:0] bus_rdata,  // Data bus read data
   output logic        bus_rd      // Data bus read select
);

   import cft_bus_pkg::*;

   typedef enum logic {
      ST_IDLE,   // No write in progress
      ST_WRITE   // nw asserted, waiting on nws
   } wr_state_t;

   wr_state_t state;
   cft_addr_u ab_view;   // I/O view of the address bus
   logic      wr_req;    // Write request this edge
   logic      wr_start;  // Request accepted

   ////////////////////////////////////////////////////////////
   // I/O block decode
   ////////////////////////////////////////////////////////////

   assign ab_view = ab;

   assign nsysdev   = !(!nio && (ab_view.io.blk == 2'd0));
   assign niodev1xx = !(!nio && (ab_view.io.blk == 2'd1));
   assign niodev2xx = !(!nio && (ab_view.io.blk == 2'd2));
   assign niodev3xx = !(!nio && (ab_view.io.blk == 2'd3));

   ////////////////////////////////////////////////////////////
   // Write cycle
   ////////////////////////////////////////////////////////////

   // Memory or I/O write, never while halted
   assign wr_req   = !nwen && (!nmem || !nio) && nhalt;
   assign wr_start = wr_req && (state == ST_IDLE);  // Busy drops requests

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:  if (wr_start) state <= ST_WRITE;
            ST_WRITE: if (nws) state <= ST_IDLE;     // Device released wait
            default:  state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_start) begin
         db_out <= ibus_in;               // Held for the whole cycle
      end
   end

   assign nw = (state != ST_WRITE);

   ////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////

   assign bus_rd    = (raddr == RADDR_DB) && !nr;
   assign bus_rdata = db_in;              // No latch, same cycle

endmodule

// File: hdl/constant_store.sv
////////////////////////////////////////////////////////////
// Final read stage
// Merges bank register, data bus and constant store
// onto the processor bus output
////////////////////////////////////////////////////////////

module constant_store (
   input  logic [4:0]  raddr,       // Microcode read address
   input  logic [7:0]  mb_rdata,    // From banking unit
   input  logic        mb_rd,       // Bank register selected
   input  logic [15:0] bus_rdata,   // From data bus driver
   input  logic        bus_rd,      // Data bus selected
   output logic [15:0] ibus_out,    // Processor bus, output side
   output logic        ibus_drive   // Some source is driving
);

   import cft_bus_pkg::*;

   logic       const_rd;    // Constant address decoded
   logic [3:0] const_idx;   // Index into constant table

   ////////////////////////////////////////////////////////////
   // Constant decode
   ////////////////////////////////////////////////////////////

   assign const_rd  = (raddr >= RADDR_CONST_BASE);   // 0x10-0x1F
   assign const_idx = 4'(raddr - RADDR_CONST_BASE);

   ////////////////////////////////////////////////////////////
   // Source select
   ////////////////////////////////////////////////////////////

   // At most one source is selected per read code
   always_comb begin
      if (const_rd) begin
         ibus_out = const_value(const_idx);
      end else if (mb_rd) begin
         ibus_out = {8'h00, mb_rdata};     // Zero-extended bank
      end else if (bus_rd) begin
         ibus_out = bus_rdata;
      end else begin
         ibus_out = 16'h0000;              // Bus released
      end
   end

   assign ibus_drive = const_rd || mb_rd || bus_rd;

endmodule

// File: hdl/card_bus.sv
////////////////////////////////////////////////////////////
// Bus board top level
// Address register, banking unit, data bus driver
// and constant store
////////////////////////////////////////////////////////////

module card_bus #(
   parameter logic [7:0] BOOT_BANK = 8'h00  // Passed to the banking unit
) (
   input  logic        clk,         // Board clock
   input  logic        reset,       // Sync, active high
   input  logic [4:0]  waddr,       // Microcode write address
   input  logic [4:0]  raddr,       // Microcode read address
   input  logic [2:0]  ir,          // IR[2:0] bank index
   input  logic        nmem,        // Memory cycle, active low
   input  logic        nio,         // I/O cycle, active low
   input  logic        nr,          // Read strobe, active low
   input  logic        nwen,        // Write enable, active low
   input  logic        nws,         // Wait state, active low
   input  logic        nhalt,       // Halted, active low
   input  logic        nfparh,      // Front panel high byte request
   input  logic [15:0] ibus_in,     // Processor bus, input side
   input  logic [15:0] db_in,       // Data bus, input side
   output logic [23:0] ab,          // Address bus
   output logic [15:0] db_out,      // Data bus, output side
   output logic        nw,          // Write strobe
   output logic        nsysdev,     // I/O 000-0FF
   output logic        niodev1xx,   // I/O 100-1FF
   output logic        niodev2xx,   // I/O 200-2FF
   output logic        niodev3xx,   // I/O 300-3FF
   output logic [15:0] ibus_out,    // Processor bus, output side
   output logic        ibus_drive,  // Processor bus driven
   output logic [7:0]  fpd          // Front panel data
);

   logic [15:0] ar;          // Stage 1 to stage 2
   logic [7:0]  mb_rdata;    // Bank read data
   logic        mb_rd;
   logic [15:0] bus_rdata;   // Data bus read data
   logic        bus_rd;

   reg_ar u_reg_ar (
      .clk, .reset, .waddr, .ibus_in, .ar
   );

   mbu #(.BOOT_BANK(BOOT_BANK)) u_mbu (
      .clk, .reset, .waddr, .raddr, .ir, .ibus_in, .ar, .nio, .nfparh,
      .ab, .mb_rdata, .mb_rd, .fpd
   );

   databus u_databus (
      .clk, .reset, .nmem, .nio, .nr, .nwen, .nws, .nhalt, .raddr, .ab,
      .ibus_in, .db_in, .db_out, .nw, .nsysdev, .niodev1xx, .niodev2xx,
      .niodev3xx, .bus_rdata, .bus_rd
   );

   constant_store u_constant_store (
      .raddr, .mb_rdata, .mb_rd, .bus_rdata, .bus_rd, .ibus_out, .ibus_drive
   );

endmodule

// File: verif/tb_card_bus.sv
////////////////////////////////////////////////////////////
// Testbench for the bus board top level
// Clock, reset, per-behavior stimulus, watchdog,
// immediate and concurrent assertion checks, error counts
////////////////////////////////////////////////////////////

module tb_card_bus;

   import cft_bus_pkg::*;

   localparam int         PERIOD       = 40;
   localparam int         DRIVE_DELAY  = 5;      // Inputs change after the edge
   localparam int         CHECK_DELAY  = 10;     // Outputs sampled mid-cycle
   localparam logic [7:0] BOOT_BANK    = 8'h80;
   localparam int         RESET_CYCLES = 16;
   localparam int         NUM_ADDR     = 16;     // AR loads with memory view
   localparam int         NUM_IO       = 8;      // AR loads with I/O view
   localparam int         NUM_WRITES   = 8;
   localparam int         MAX_WAIT     = 5;      // Longest nws stretch
   localparam int         NUM_DB       = 8;

   // Cycle count of each section in run order
   localparam int TEST_CYCLES = RESET_CYCLES + 1 + 8 + 8 + NUM_ADDR * 4 + 8
                              + NUM_IO * 4 + 16 + NUM_WRITES * (MAX_WAIT + 3) + 3
                              + NUM_DB + 1;
   localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * PERIOD;  // Double for margin

   logic        clk;
   logic        reset;
   logic [4:0]  waddr;
   logic [4:0]  raddr;
   logic [2:0]  ir;
   logic        nmem, nio, nr, nwen, nws, nhalt, nfparh;
   logic [15:0] ibus_in;
   logic [15:0] db_in;
   logic [23:0] ab;
   logic [15:0] db_out;
   logic        nw;
   logic        nsysdev, niodev1xx, niodev2xx, niodev3xx;
   logic [15:0] ibus_out;
   logic        ibus_drive;
   logic [7:0]  fpd;

   logic [3:0]  io_sel;             // Block selects from 3xx down to sys
   logic [3:0]  io_exp;             // Expected selects from ab and nio
   logic [7:0]  bank_model [8];     // Reference copy of MB0-MB7
   integer      seed;
   int          checks        = 0;
   int          errors        = 0;
   int          assert_errors = 0;  // Concurrent check failures

   card_bus #(.BOOT_BANK(BOOT_BANK)) UUT (
      .clk, .reset, .waddr, .raddr, .ir, .nmem, .nio, .nr, .nwen, .nws, .nhalt,
      .nfparh, .ibus_in, .db_in, .ab, .db_out, .nw, .nsysdev, .niodev1xx,
      .niodev2xx, .niodev3xx, .ibus_out, .ibus_drive, .fpd
   );

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // I/O decode checked on every edge out of reset
   ////////////////////////////////////////////////////////////

   assign io_sel = {niodev3xx, niodev2xx, niodev1xx, nsysdev};

   always_comb begin
      io_exp = 4'hf;                     // Nothing selected in memory cycles
      if (!nio) begin
         io_exp[ab[9:8]] = 1'b0;         // Block field of the I/O view
      end
   end

   assert property (@(posedge clk) disable iff (reset) io_sel == io_exp)
      else begin
         assert_errors++;
         $display("CHECK FAILED io_sel got 0x%h expected 0x%h",
                  $sampled(io_sel), $sampled(io_exp));
      end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [23:0] got,
                              input logic [23:0] expected);
      checks++;
      assert (got === expected) else begin
         errors++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   task automatic idle_inputs();
      waddr   = 5'h00;                   // No write code
      raddr   = 5'h00;                   // No read source
      ir      = 3'd0;
      nmem    = 1'b1;
      nio     = 1'b1;
      nr      = 1'b1;
      nwen    = 1'b1;
      nws     = 1'b1;
      nhalt   = 1'b1;
      nfparh  = 1'b1;
      ibus_in = 16'h0000;
      db_in   = 16'h0000;
   endtask

   task automatic write_bank(input logic [2:0] idx, input logic [15:0] word);
      waddr   = WADDR_MBN;
      ir      = idx;
      ibus_in = word;                    // High byte must be dropped
      next_cycle();
      waddr = 5'h00;
   endtask

   task automatic read_bank(input logic [2:0] idx, input logic [7:0] expected);
      ir    = idx;
      raddr = RADDR_MBN;
      #(CHECK_DELAY);
      check_value("ibus_out", 24'(ibus_out), {16'h0000, expected});
      check_value("ibus_drive", 24'(ibus_drive), 24'h1);
      next_cycle();
      raddr = 5'h00;
   endtask

   // AR loads at the first edge and ab at the second
   task automatic load_ar(input logic [15:0] addr, input logic nio_v);
      waddr   = WADDR_AR;
      ibus_in = addr;
      nio     = nio_v;
      next_cycle();
      waddr = 5'h00;
      next_cycle();
   endtask

   task automatic write_cycle(input logic [15:0] data, input int wait_n,
                              input logic use_io);
      nwen    = 1'b0;
      nmem    = use_io;                  // Memory or I/O write
      nio     = ~use_io;
      ibus_in = data;
      next_cycle();
      ibus_in = ~data;                   // Held request must be ignored
      nws     = (wait_n == 0);
      #(CHECK_DELAY);
      check_value("nw", 24'(nw), 24'h0);
      check_value("db_out", 24'(db_out), 24'(data));
      for (int j = 0; j < wait_n; j++) begin
         next_cycle();
         if (j == wait_n - 1) begin
            nws = 1'b1;                  // Device ready at next edge
         end
         #(CHECK_DELAY);
         check_value("nw", 24'(nw), 24'h0);
         check_value("db_out", 24'(db_out), 24'(data));
      end
      next_cycle();
      nwen = 1'b1;
      nmem = 1'b1;
      nio  = 1'b1;
      #(CHECK_DELAY);
      check_value("nw", 24'(nw), 24'h1);
      check_value("db_out", 24'(db_out), 24'(data));
      next_cycle();
   endtask

   ////////////////////////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog timeout, test sequence did not finish in %0d time units",
               WATCHDOG_TIME);
      $display("Simulation failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      logic [15:0] word;
      logic [1:0]  blk;
      logic [3:0]  exp_sel;
      int          wait_n;

      seed = 83989;
      idle_inputs();
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      reset = 1'b0;

      // Reset state checked before the first edge out of reset
      #(CHECK_DELAY);
      check_value("nw", 24'(nw), 24'h1);
      check_value("ibus_drive", 24'(ibus_drive), 24'h0);
      check_value("ab", ab, 24'h000000);
      next_cycle();
      for (int n = 0; n < 8; n++) begin
         read_bank(3'(n), BOOT_BANK);
      end

      // Address extension through the memory view
      for (int n = 0; n < 8; n++) begin
         word = 16'($random(seed));
         write_bank(3'(n), word);
         bank_model[3'(n)] = word[7:0];
      end
      for (int k = 0; k < NUM_ADDR; k++) begin
         word = 16'($random(seed));
         nfparh = 1'b1;
         load_ar(word, 1'b1);
         #(CHECK_DELAY);
         check_value("ab", ab, {bank_model[word[15:13]], word});
         check_value("fpd", 24'(fpd), 24'(word[7:0]));
         next_cycle();
         nfparh = 1'b0;                  // Ask for the bank byte
         #(CHECK_DELAY);
         check_value("fpd", 24'(fpd), 24'(bank_model[word[15:13]]));
         next_cycle();
      end
      nfparh = 1'b1;
      for (int n = 0; n < 8; n++) begin
         read_bank(3'(n), bank_model[3'(n)]);
      end

      // I/O cycles with each block twice
      for (int k = 0; k < NUM_IO; k++) begin
         blk  = 2'(k);
         word = {6'h00, blk, 8'($random(seed))};
         load_ar(word, 1'b0);
         #(CHECK_DELAY);
         check_value("ab", ab, {8'h00, word});
         exp_sel      = 4'hf;
         exp_sel[blk] = 1'b0;
         check_value("io_sel", 24'(io_sel), 24'(exp_sel));
         next_cycle();
         nio = 1'b1;
         #(CHECK_DELAY);
         check_value("io_sel", 24'(io_sel), 24'h00000f);
         next_cycle();
      end

      // Constant store over the full range
      for (int i = 0; i < 16; i++) begin
         raddr = RADDR_CONST_BASE + 5'(i);
         #(CHECK_DELAY);
         check_value("ibus_out", 24'(ibus_out), 24'(const_value(4'(i))));
         check_value("ibus_drive", 24'(ibus_drive), 24'h1);
         next_cycle();
      end
      raddr = 5'h00;

      // Write cycles with random wait stretch
      for (int k = 0; k < NUM_WRITES; k++) begin
         word   = 16'($random(seed));
         wait_n = $unsigned($random(seed)) % (MAX_WAIT + 1);
         write_cycle(word, wait_n, k[0]);
      end
      nhalt   = 1'b0;                    // Requests while halted
      nwen    = 1'b0;
      nmem    = 1'b0;
      ibus_in = 16'($random(seed));
      repeat (2) begin
         next_cycle();
         #(CHECK_DELAY);
         check_value("nw", 24'(nw), 24'h1);
      end
      next_cycle();
      nwen  = 1'b1;
      nmem  = 1'b1;
      nhalt = 1'b1;

      // Data bus reads in the same cycle
      for (int k = 0; k < NUM_DB; k++) begin
         word  = 16'($random(seed));
         db_in = word;
         raddr = RADDR_DB;
         nr    = 1'b0;
         #(CHECK_DELAY);
         check_value("ibus_out", 24'(ibus_out), 24'(word));
         check_value("ibus_drive", 24'(ibus_drive), 24'h1);
         next_cycle();
      end
      nr = 1'b1;                         // Read code alone drives nothing
      #(CHECK_DELAY);
      check_value("ibus_drive", 24'(ibus_drive), 24'h0);
      next_cycle();
      raddr = 5'h00;

      $display("Checks run %0d, check errors %0d, assertion errors %0d",
               checks, errors, assert_errors);
      if (errors == 0 && assert_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: all.f
hdl/cft_bus_pkg.sv
hdl/reg_ar.sv
hdl/mbu.sv
hdl/databus.sv
hdl/constant_store.sv
hdl/card_bus.sv
verif/tb_card_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus board testbench with Verilator and runs it.
# The run passes only when the pass message shows up in its output.

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert --top-module tb_card_bus -f all.f \
      && ./obj_dir/Vtb_card_bus) \
   || { echo "$out"; echo "Verilator build or simulation run did not complete"; exit 1; }

echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
